//--- design/sbox_settings.svh
`ifndef SBOX_SETTINGS_SVH
`define SBOX_SETTINGS_SVH

// Fixed by the Boyar-Peralta style circuit
`define SBOX_BYTE_W  8
`define SBOX_INNER_W 21  // Top layer output, core input
`define SBOX_MID_W   18  // Core output, bottom layer input

`endif

//--- design/sbox_pkg.sv
`default_nettype none

`include "sbox_settings.svh"

package sbox_pkg;

    // Substitution selected per byte
    typedef enum logic [1:0] {
        SBOX_AES_FWD = 2'd0,
        SBOX_AES_INV = 2'd1,
        SBOX_SM4     = 2'd2  // 2'd3 reserved
    } sbox_op_e;

    typedef logic [`SBOX_INNER_W-1:0] sbox_inner_t;
    typedef logic [`SBOX_MID_W-1:0]   sbox_mid_t;

endpackage

`default_nettype wire

//--- design/sbox_inner_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sbox_settings.svh"

// Top linear layers, each maps the byte into the shared core basis
module sbox_inner_layer (
    input  wire [`SBOX_BYTE_W-1:0] i_byte,
    input  wire sbox_pkg::sbox_op_e i_op,
    output sbox_pkg::sbox_inner_t  o_inner
);
    import sbox_pkg::*;

    wire [5:0]        aes_t;
    wire [4:0]        inv_t;
    wire [6:0]        sm4_t;
    wire sbox_inner_t aes_y;
    wire sbox_inner_t inv_y;
    wire sbox_inner_t sm4_y;

    // Forward AES
    assign aes_t[0]  = i_byte[3] ^ i_byte[1];
    assign aes_t[1]  = i_byte[6] ^ i_byte[5];
    assign aes_t[2]  = i_byte[6] ^ i_byte[2];
    assign aes_t[3]  = i_byte[5] ^ i_byte[2];
    assign aes_t[4]  = i_byte[4] ^ i_byte[0];
    assign aes_t[5]  = i_byte[1] ^ i_byte[0];
    assign aes_y[0]  = i_byte[0];
    assign aes_y[1]  = i_byte[7] ^ i_byte[4];
    assign aes_y[2]  = i_byte[7] ^ i_byte[2];
    assign aes_y[3]  = i_byte[7] ^ i_byte[1];
    assign aes_y[4]  = i_byte[4] ^ i_byte[2];
    assign aes_y[5]  = aes_y[1] ^ aes_t[0];
    assign aes_y[6]  = i_byte[0] ^ aes_y[5];
    assign aes_y[7]  = i_byte[0] ^ aes_t[1];
    assign aes_y[8]  = aes_y[5] ^ aes_t[1];
    assign aes_y[9]  = aes_y[3] ^ aes_y[4];
    assign aes_y[10] = aes_y[5] ^ aes_t[2];
    assign aes_y[11] = aes_t[0] ^ aes_t[2];
    assign aes_y[12] = aes_t[0] ^ aes_t[3];
    assign aes_y[13] = aes_y[7] ^ aes_y[12];
    assign aes_y[14] = aes_t[1] ^ aes_t[4];
    assign aes_y[15] = aes_y[1] ^ aes_y[14];
    assign aes_y[16] = aes_t[1] ^ aes_t[5];
    assign aes_y[17] = aes_y[2] ^ aes_y[16];
    assign aes_y[18] = aes_y[2] ^ aes_y[8];
    assign aes_y[19] = aes_y[15] ^ aes_y[13];
    assign aes_y[20] = aes_y[1] ^ aes_t[3];

    // Inverse AES, XNORs fold in the inverse affine constant
    assign inv_t[0]  = i_byte[1] ^ i_byte[0];
    assign inv_t[1]  = i_byte[6] ^ i_byte[1];
    assign inv_t[2]  = i_byte[5] ~^ i_byte[2];
    assign inv_t[3]  = i_byte[2] ~^ i_byte[1];
    assign inv_t[4]  = i_byte[5] ~^ i_byte[3];
    assign inv_y[17] = i_byte[7] ^ i_byte[4];
    assign inv_y[16] = i_byte[6] ~^ i_byte[4];
    assign inv_y[2]  = i_byte[7] ~^ i_byte[6];
    assign inv_y[1]  = i_byte[4] ^ i_byte[3];
    assign inv_y[18] = i_byte[3] ~^ i_byte[0];
    assign inv_y[6]  = i_byte[6] ~^ inv_y[17];
    assign inv_y[14] = inv_y[16] ^ inv_t[0];
    assign inv_y[7]  = i_byte[0] ~^ inv_y[1];
    assign inv_y[8]  = inv_y[2] ^ inv_y[18];
    assign inv_y[9]  = inv_y[2] ^ inv_t[0];
    assign inv_y[3]  = inv_y[1] ^ inv_t[0];
    assign inv_y[19] = i_byte[5] ~^ inv_y[1];
    assign inv_y[13] = i_byte[5] ~^ inv_y[14];
    assign inv_y[15] = inv_y[18] ^ inv_t[1];
    assign inv_y[4]  = i_byte[3] ^ inv_y[6];
    assign inv_y[5]  = inv_y[16] ^ inv_t[2];
    assign inv_y[12] = inv_t[1] ^ inv_t[4];
    assign inv_y[20] = inv_y[1] ^ inv_t[3];
    assign inv_y[11] = inv_y[8] ^ inv_y[20];
    assign inv_y[10] = inv_y[8] ^ inv_t[3];
    assign inv_y[0]  = i_byte[7] ^ inv_t[2];

    // SM4
    assign sm4_t[0]  = i_byte[3] ^ i_byte[4];
    assign sm4_t[1]  = i_byte[2] ^ i_byte[7];
    assign sm4_t[2]  = i_byte[7] ^ sm4_y[18];
    assign sm4_t[3]  = i_byte[1] ^ sm4_t[1];
    assign sm4_t[4]  = i_byte[6] ^ i_byte[7];
    assign sm4_t[5]  = i_byte[0] ^ sm4_y[18];
    assign sm4_t[6]  = i_byte[3] ^ i_byte[6];
    assign sm4_y[18] = i_byte[2] ^ i_byte[6];
    assign sm4_y[10] = i_byte[1] ^ sm4_y[18];
    assign sm4_y[0]  = i_byte[5] ~^ sm4_y[10];
    assign sm4_y[1]  = sm4_t[0] ^ sm4_t[3];
    assign sm4_y[2]  = i_byte[0] ^ sm4_t[0];
    assign sm4_y[4]  = i_byte[0] ^ sm4_t[3];
    assign sm4_y[3]  = i_byte[3] ^ sm4_y[4];
    assign sm4_y[5]  = i_byte[5] ^ sm4_t[5];
    assign sm4_y[6]  = i_byte[0] ~^ i_byte[1];
    assign sm4_y[7]  = sm4_t[0] ~^ sm4_y[10];
    assign sm4_y[8]  = sm4_t[0] ^ sm4_t[5];
    assign sm4_y[9]  = i_byte[3];
    assign sm4_y[11] = sm4_t[0] ^ sm4_t[4];
    assign sm4_y[12] = i_byte[5] ^ sm4_t[4];
    assign sm4_y[13] = i_byte[5] ~^ sm4_y[1];
    assign sm4_y[14] = i_byte[4] ~^ sm4_t[2];
    assign sm4_y[15] = i_byte[1] ~^ sm4_t[6];
    assign sm4_y[16] = i_byte[0] ~^ sm4_t[2];
    assign sm4_y[17] = sm4_t[0] ~^ sm4_t[2];
    assign sm4_y[19] = i_byte[5] ~^ sm4_y[14];
    assign sm4_y[20] = i_byte[0] ^ sm4_t[1];

    always_comb begin
        case (i_op)
            SBOX_AES_INV: o_inner = inv_y;
            SBOX_AES_FWD: o_inner = aes_y;
            default:      o_inner = sm4_y;  // SM4, reserved code lands here too
        endcase
    end

endmodule

`default_nettype wire

//--- design/sbox_nonlinear_core.sv
`timescale 1ns/1ps
`default_nettype none

// Shared GF(256) inversion network
// AES, inverse AES and SM4 are all Nyberg S-boxes, so one copy serves all three
module sbox_nonlinear_core (
    input  wire sbox_pkg::sbox_inner_t i_inner,
    output wire sbox_pkg::sbox_mid_t   o_mid
);

    wire [45:0] t;

    // First AND level and GF(16) input sums
    assign t[0]  = i_inner[3] ^ i_inner[12];
    assign t[1]  = i_inner[9] & i_inner[5];
    assign t[2]  = i_inner[17] & i_inner[6];
    assign t[3]  = i_inner[10] ^ t[1];
    assign t[4]  = i_inner[14] & i_inner[0];
    assign t[5]  = t[4] ^ t[1];
    assign t[6]  = i_inner[3] & i_inner[12];
    assign t[7]  = i_inner[16] & i_inner[7];
    assign t[8]  = t[0] ^ t[6];
    assign t[9]  = i_inner[15] & i_inner[13];
    assign t[10] = t[9] ^ t[6];
    assign t[11] = i_inner[1] & i_inner[11];
    assign t[12] = i_inner[4] & i_inner[20];
    assign t[13] = t[12] ^ t[11];
    assign t[14] = i_inner[2] & i_inner[8];
    assign t[15] = t[14] ^ t[11];
    assign t[16] = t[3] ^ t[2];
    assign t[17] = t[5] ^ i_inner[18];
    assign t[18] = t[8] ^ t[7];
    assign t[19] = t[10] ^ t[15];
    assign t[20] = t[16] ^ t[13];
    assign t[21] = t[17] ^ t[15];
    assign t[22] = t[18] ^ t[13];
    assign t[23] = t[19] ^ i_inner[19];

    // GF(16) inversion
    assign t[24] = t[22] ^ t[23];
    assign t[25] = t[22] & t[20];
    assign t[26] = t[21] ^ t[25];
    assign t[27] = t[20] ^ t[21];
    assign t[28] = t[23] ^ t[25];
    assign t[29] = t[28] & t[27];
    assign t[30] = t[26] & t[24];
    assign t[31] = t[20] & t[23];
    assign t[32] = t[27] & t[31];
    assign t[33] = t[27] ^ t[25];
    assign t[34] = t[21] & t[22];
    assign t[35] = t[24] & t[34];
    assign t[36] = t[24] ^ t[25];
    assign t[37] = t[21] ^ t[29];
    assign t[38] = t[32] ^ t[33];
    assign t[39] = t[23] ^ t[30];
    assign t[40] = t[35] ^ t[36];
    assign t[41] = t[38] ^ t[40];
    assign t[42] = t[37] ^ t[39];
    assign t[43] = t[37] ^ t[38];
    assign t[44] = t[39] ^ t[40];
    assign t[45] = t[42] ^ t[41];

    // Output products, recombined by the bottom layers
    assign o_mid[0]  = t[38] & i_inner[7];
    assign o_mid[1]  = t[37] & i_inner[13];
    assign o_mid[2]  = t[42] & i_inner[11];
    assign o_mid[3]  = t[45] & i_inner[20];
    assign o_mid[4]  = t[41] & i_inner[8];
    assign o_mid[5]  = t[44] & i_inner[9];
    assign o_mid[6]  = t[40] & i_inner[17];
    assign o_mid[7]  = t[39] & i_inner[14];
    assign o_mid[8]  = t[43] & i_inner[3];
    assign o_mid[9]  = t[38] & i_inner[16];
    assign o_mid[10] = t[37] & i_inner[15];
    assign o_mid[11] = t[42] & i_inner[1];
    assign o_mid[12] = t[45] & i_inner[4];
    assign o_mid[13] = t[41] & i_inner[2];
    assign o_mid[14] = t[44] & i_inner[5];
    assign o_mid[15] = t[40] & i_inner[6];
    assign o_mid[16] = t[39] & i_inner[0];
    assign o_mid[17] = t[43] & i_inner[12];

endmodule

`default_nettype wire

//--- design/sbox_outer_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sbox_settings.svh"

// Bottom linear layers, XNORs carry the affine output constants
module sbox_outer_layer (
    input  wire sbox_pkg::sbox_mid_t  i_mid,
    input  wire sbox_pkg::sbox_op_e   i_op,
    output logic [`SBOX_BYTE_W-1:0]   o_byte
);
    import sbox_pkg::*;

    wire [29:0]             aes_t;
    wire [28:0]             inv_t;
    wire [29:0]             sm4_t;
    wire [`SBOX_BYTE_W-1:0] aes_y;
    wire [`SBOX_BYTE_W-1:0] inv_y;
    wire [`SBOX_BYTE_W-1:0] sm4_y;

    // Forward AES
    assign aes_t[0]  = i_mid[11] ^ i_mid[12];
    assign aes_t[1]  = i_mid[0] ^ i_mid[6];
    assign aes_t[2]  = i_mid[14] ^ i_mid[16];
    assign aes_t[3]  = i_mid[15] ^ i_mid[5];
    assign aes_t[4]  = i_mid[4] ^ i_mid[8];
    assign aes_t[5]  = i_mid[17] ^ i_mid[11];
    assign aes_t[6]  = i_mid[12] ^ aes_t[5];
    assign aes_t[7]  = i_mid[14] ^ aes_t[3];
    assign aes_t[8]  = i_mid[1] ^ i_mid[9];
    assign aes_t[9]  = i_mid[2] ^ i_mid[3];
    assign aes_t[10] = i_mid[3] ^ aes_t[4];
    assign aes_t[11] = i_mid[10] ^ aes_t[2];
    assign aes_t[12] = i_mid[16] ^ i_mid[1];
    assign aes_t[13] = i_mid[0] ^ aes_t[0];
    assign aes_t[14] = i_mid[2] ^ i_mid[11];
    assign aes_t[15] = i_mid[5] ^ aes_t[1];
    assign aes_t[16] = i_mid[6] ^ aes_t[0];
    assign aes_t[17] = i_mid[7] ^ aes_t[1];
    assign aes_t[18] = i_mid[8] ^ aes_t[8];
    assign aes_t[19] = i_mid[13] ^ aes_t[4];
    assign aes_t[20] = aes_t[0] ^ aes_t[1];
    assign aes_t[21] = aes_t[1] ^ aes_t[7];
    assign aes_t[22] = aes_t[3] ^ aes_t[12];
    assign aes_t[23] = aes_t[18] ^ aes_t[2];
    assign aes_t[24] = aes_t[15] ^ aes_t[9];
    assign aes_t[25] = aes_t[6] ^ aes_t[10];
    assign aes_t[26] = aes_t[7] ^ aes_t[9];
    assign aes_t[27] = aes_t[8] ^ aes_t[10];
    assign aes_t[28] = aes_t[11] ^ aes_t[14];
    assign aes_t[29] = aes_t[11] ^ aes_t[17];
    assign aes_y[0]  = aes_t[6] ~^ aes_t[23];
    assign aes_y[1]  = aes_t[13] ~^ aes_t[27];
    assign aes_y[2]  = aes_t[25] ^ aes_t[29];
    assign aes_y[3]  = aes_t[20] ^ aes_t[22];
    assign aes_y[4]  = aes_t[6] ^ aes_t[21];
    assign aes_y[5]  = aes_t[19] ~^ aes_t[28];
    assign aes_y[6]  = aes_t[16] ~^ aes_t[26];
    assign aes_y[7]  = aes_t[6] ^ aes_t[24];

    // Inverse AES, no constant here since the top layer absorbed it
    assign inv_t[0]  = i_mid[2] ^ i_mid[11];
    assign inv_t[1]  = i_mid[8] ^ i_mid[9];
    assign inv_t[2]  = i_mid[4] ^ i_mid[12];
    assign inv_t[3]  = i_mid[15] ^ i_mid[0];
    assign inv_t[4]  = i_mid[16] ^ i_mid[6];
    assign inv_t[5]  = i_mid[14] ^ i_mid[1];
    assign inv_t[6]  = i_mid[17] ^ i_mid[10];
    assign inv_t[7]  = inv_t[0] ^ inv_t[1];
    assign inv_t[8]  = i_mid[0] ^ i_mid[3];
    assign inv_t[9]  = i_mid[5] ^ i_mid[13];
    assign inv_t[10] = i_mid[7] ^ inv_t[4];
    assign inv_t[11] = inv_t[0] ^ inv_t[3];
    assign inv_t[12] = i_mid[14] ^ i_mid[16];
    assign inv_t[13] = i_mid[17] ^ i_mid[1];
    assign inv_t[14] = i_mid[17] ^ i_mid[12];
    assign inv_t[15] = i_mid[4] ^ i_mid[9];
    assign inv_t[16] = i_mid[7] ^ i_mid[11];
    assign inv_t[17] = i_mid[8] ^ inv_t[2];
    assign inv_t[18] = i_mid[13] ^ inv_t[5];
    assign inv_t[19] = inv_t[2] ^ inv_t[3];
    assign inv_t[20] = inv_t[4] ^ inv_t[6];
    assign inv_t[21] = inv_t[2] ^ inv_t[7];
    assign inv_t[22] = inv_t[7] ^ inv_t[8];
    assign inv_t[23] = inv_t[5] ^ inv_t[7];
    assign inv_t[24] = inv_t[6] ^ inv_t[10];
    assign inv_t[25] = inv_t[9] ^ inv_t[11];
    assign inv_t[26] = inv_t[10] ^ inv_t[18];
    assign inv_t[27] = inv_t[11] ^ inv_t[24];
    assign inv_t[28] = inv_t[15] ^ inv_t[20];
    assign inv_y[0]  = inv_t[9] ^ inv_t[16];
    assign inv_y[1]  = inv_t[14] ^ inv_t[22];
    assign inv_y[2]  = inv_t[19] ^ inv_t[23];
    assign inv_y[3]  = inv_t[22] ^ inv_t[26];
    assign inv_y[4]  = inv_t[12] ^ inv_t[21];
    assign inv_y[5]  = inv_t[17] ^ inv_t[27];
    assign inv_y[6]  = inv_t[25] ^ inv_t[28];
    assign inv_y[7]  = inv_t[13] ^ inv_t[21];

    // SM4
    assign sm4_t[0]  = i_mid[4] ^ i_mid[7];
    assign sm4_t[1]  = i_mid[13] ^ i_mid[15];
    assign sm4_t[2]  = i_mid[2] ^ i_mid[16];
    assign sm4_t[3]  = i_mid[6] ^ sm4_t[0];
    assign sm4_t[4]  = i_mid[12] ^ sm4_t[1];
    assign sm4_t[5]  = i_mid[9] ^ i_mid[10];
    assign sm4_t[6]  = i_mid[11] ^ sm4_t[2];
    assign sm4_t[7]  = i_mid[1] ^ sm4_t[4];
    assign sm4_t[8]  = i_mid[0] ^ i_mid[17];
    assign sm4_t[9]  = i_mid[3] ^ i_mid[17];
    assign sm4_t[10] = i_mid[8] ^ sm4_t[3];
    assign sm4_t[11] = sm4_t[2] ^ sm4_t[5];
    assign sm4_t[12] = i_mid[14] ^ sm4_t[6];
    assign sm4_t[13] = sm4_t[7] ^ sm4_t[9];
    assign sm4_t[14] = i_mid[0] ^ i_mid[6];
    assign sm4_t[15] = i_mid[7] ^ i_mid[16];
    assign sm4_t[16] = i_mid[5] ^ i_mid[13];
    assign sm4_t[17] = i_mid[3] ^ i_mid[15];
    assign sm4_t[18] = i_mid[10] ^ i_mid[12];
    assign sm4_t[19] = i_mid[9] ^ sm4_t[1];
    assign sm4_t[20] = i_mid[4] ^ sm4_t[4];
    assign sm4_t[21] = i_mid[14] ^ sm4_t[3];
    assign sm4_t[22] = i_mid[16] ^ sm4_t[5];
    assign sm4_t[23] = sm4_t[7] ^ sm4_t[14];
    assign sm4_t[24] = sm4_t[8] ^ sm4_t[11];
    assign sm4_t[25] = sm4_t[0] ^ sm4_t[12];
    assign sm4_t[26] = sm4_t[17] ^ sm4_t[3];
    assign sm4_t[27] = sm4_t[18] ^ sm4_t[10];
    assign sm4_t[28] = sm4_t[19] ^ sm4_t[6];
    assign sm4_t[29] = sm4_t[8] ^ sm4_t[10];
    assign sm4_y[0]  = sm4_t[11] ~^ sm4_t[13];
    assign sm4_y[1]  = sm4_t[15] ~^ sm4_t[23];
    assign sm4_y[2]  = sm4_t[20] ^ sm4_t[24];
    assign sm4_y[3]  = sm4_t[16] ^ sm4_t[25];
    assign sm4_y[4]  = sm4_t[26] ~^ sm4_t[22];
    assign sm4_y[5]  = sm4_t[21] ^ sm4_t[13];
    assign sm4_y[6]  = sm4_t[27] ~^ sm4_t[12];
    assign sm4_y[7]  = sm4_t[28] ~^ sm4_t[29];

    // Same priority as the top layer select
    always_comb begin
        case (i_op)
            SBOX_AES_INV: o_byte = inv_y;
            SBOX_AES_FWD: o_byte = aes_y;
            default:      o_byte = sm4_y;
        endcase
    end

endmodule

`default_nettype wire

//--- design/sbox_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "sbox_settings.svh"

// Combined AES / AES^-1 / SM4 byte substitution, one cycle latency
module sbox_unit (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_valid,
    input  wire sbox_pkg::sbox_op_e i_op,
    input  wire [`SBOX_BYTE_W-1:0]  i_byte,
    output logic                    o_valid,
    output wire [`SBOX_BYTE_W-1:0]  o_byte
);
    import sbox_pkg::*;

    sbox_inner_t inner;
    sbox_mid_t   mid;
    sbox_mid_t   mid_q;  // Stage register splits the depth-16 path here
    sbox_op_e    op_q;

    sbox_inner_layer u_inner (
        .i_byte  (i_byte),
        .i_op    (i_op),
        .o_inner (inner)
    );

    sbox_nonlinear_core u_core (
        .i_inner (inner),
        .o_mid   (mid)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            mid_q   <= '0;
            op_q    <= SBOX_AES_FWD;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin  // Hold the last result between strobes
                mid_q <= mid;
                op_q  <= i_op;
            end
        end
    end

    sbox_outer_layer u_outer (
        .i_mid  (mid_q),
        .i_op   (op_q),
        .o_byte (o_byte)
    );

    // Reserved code would silently fall into the SM4 path on both layers
    a_op_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> (i_op inside {SBOX_AES_FWD, SBOX_AES_INV, SBOX_SM4}));

    a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        1'b1 |=> (o_valid == $past(i_valid)));

endmodule

`default_nettype wire

//--- tests/sbox_ref_model.svh
`ifndef SBOX_REF_MODEL_SVH
`define SBOX_REF_MODEL_SVH

// GF(2^8) product modulo x^8+x^4+x^3+x+1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i])
            acc ^= sh;
        sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);  // xtime
    end
    return acc;
endfunction

// a^254 is the inverse, and 0 stays 0
function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 0; i < 254; i++)
        r = gf_mul(r, a);
    return r;
endfunction

// AES affine map over the field inverse
function automatic logic [7:0] aes_fwd_ref(input logic [7:0] x);
    logic [7:0] y;
    y = gf_inv(x);
    return y ^ {y[6:0], y[7]} ^ {y[5:0], y[7:6]} ^ {y[4:0], y[7:5]}
             ^ {y[3:0], y[7:4]} ^ 8'h63;
endfunction

// First row of the published SM4 S-box
function automatic logic [7:0] sm4_head_ref(input logic [3:0] n);
    case (n)
        4'h0: return 8'hd6;
        4'h1: return 8'h90;
        4'h2: return 8'he9;
        4'h3: return 8'hfe;
        4'h4: return 8'hcc;
        4'h5: return 8'he1;
        4'h6: return 8'h3d;
        4'h7: return 8'hb7;
        4'h8: return 8'h16;
        4'h9: return 8'hb6;
        4'ha: return 8'h14;
        4'hb: return 8'hc2;
        4'hc: return 8'h28;
        4'hd: return 8'hfb;
        4'he: return 8'h2c;
        default: return 8'h05;
    endcase
endfunction

`endif

//--- tests/sbox_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sbox_settings.svh"

module sbox_unit_tb;
    import sbox_pkg::*;

    `include "sbox_ref_model.svh"

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_valid;
    sbox_op_e                i_op;
    logic [`SBOX_BYTE_W-1:0] i_byte;
    wire                     o_valid;
    wire  [`SBOX_BYTE_W-1:0] o_byte;

    // Expectation for the byte now on the inputs
    logic                    chk_d;
    logic                    uniq_d;
    logic [`SBOX_BYTE_W-1:0] exp_d;

    // Same expectation one cycle later to line up with o_byte
    logic                    vld_q;
    logic                    chk_q;
    logic                    uniq_q;
    logic [`SBOX_BYTE_W-1:0] exp_q;

    logic [255:0] seen;  // SM4 outputs observed so far
    logic         seen_clr;
    int           fail_cnt = 0;
    int           chk_cnt = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;

    sbox_unit uut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_op    (i_op),
        .i_byte  (i_byte),
        .o_valid (o_valid),
        .o_byte  (o_byte)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q  <= 1'b0;
            chk_q  <= 1'b0;
            uniq_q <= 1'b0;
            exp_q  <= '0;
        end else begin
            vld_q  <= i_valid;
            chk_q  <= i_valid & chk_d;
            uniq_q <= i_valid & uniq_d;
            exp_q  <= exp_d;
        end
    end

    always @(posedge i_clk) begin
        if (seen_clr)
            seen <= '0;
        else if (i_rst_n && o_valid && uniq_q)
            seen[o_byte] <= 1'b1;
        if (i_rst_n && o_valid && chk_q)
            chk_cnt <= chk_cnt + 1;
    end

    a_rst_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !o_valid)
        else begin
            $display("FAIL t=%0t o_valid exp=0 got=%0b", $time, $sampled(o_valid));
            fail_cnt++;
        end

    a_valid_follow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid == vld_q)
        else begin
            $display("FAIL t=%0t o_valid exp=%0b got=%0b", $time,
                     $sampled(vld_q), $sampled(o_valid));
            fail_cnt++;
        end

    a_byte_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && chk_q) |-> (o_byte == exp_q))
        else begin
            $display("FAIL t=%0t o_byte exp=%02h got=%02h", $time,
                     $sampled(exp_q), $sampled(o_byte));
            fail_cnt++;
        end

    a_sm4_distinct: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && uniq_q) |-> !seen[o_byte])
        else begin
            $display("Error at t=%0t: SM4 output %02h came out twice", $time,
                     $sampled(o_byte));
            fail_cnt++;
        end

    // One input cycle launched just after the rising edge
    task automatic drive(input logic vld, input sbox_op_e op, input logic [7:0] b,
                         input logic chk, input logic [7:0] exp, input logic uniq);
        @(posedge i_clk);
        #1;
        i_valid = vld;
        i_op    = op;
        i_byte  = b;
        chk_d   = chk;
        exp_d   = exp;
        uniq_d  = uniq;
    endtask

    task automatic drain();
        bit done;
        done = 1'b0;
        drive(1'b0, SBOX_AES_FWD, 8'h00, 1'b0, 8'h00, 1'b0);
        for (int n = 0; n < 8 && !done; n++) begin
            @(posedge i_clk);
            #1;
            done = !o_valid;
        end
        if (!done) begin
            $display("Timeout: o_valid stayed high after the last strobe");
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic report(input string name, input int fails0, input int chks0);
        $display("%-10s done, %0d byte checks, %0d errors", name,
                 chk_cnt - chks0, fail_cnt - fails0);
        if (fail_cnt == fails0)
            tests_ok++;
        else
            tests_bad++;
    endtask

    // Errors from the reset phase itself belong to this test
    task automatic idle_after_reset();
        for (int n = 0; n < 4; n++)
            drive(1'b0, SBOX_AES_FWD, 8'($urandom), 1'b0, 8'h00, 1'b0);
        drain();
        report("reset", 0, chk_cnt);
    endtask

    task automatic aes_forward_sweep();
        int fails0;
        int chks0;
        fails0 = fail_cnt;
        chks0  = chk_cnt;
        drive(1'b1, SBOX_AES_FWD, 8'h00, 1'b1, 8'h63, 1'b0);  // Known answers first
        drive(1'b1, SBOX_AES_FWD, 8'h01, 1'b1, 8'h7c, 1'b0);
        drive(1'b1, SBOX_AES_FWD, 8'h53, 1'b1, 8'hed, 1'b0);
        for (int b = 0; b < 256; b++)
            drive(1'b1, SBOX_AES_FWD, 8'(b), 1'b1, aes_fwd_ref(8'(b)), 1'b0);
        drain();
        report("aes_fwd", fails0, chks0);
    endtask

    task automatic aes_inverse_roundtrip();
        int         fails0;
        int         chks0;
        logic [7:0] b;
        fails0 = fail_cnt;
        chks0  = chk_cnt;
        for (int n = 0; n < 256; n++) begin
            b = 8'($urandom);
            drive(1'b1, SBOX_AES_INV, aes_fwd_ref(b), 1'b1, b, 1'b0);
        end
        drain();
        report("aes_inv", fails0, chks0);
    endtask

    task automatic sm4_sweep();
        int fails0;
        int chks0;
        fails0 = fail_cnt;
        chks0  = chk_cnt;
        @(posedge i_clk);
        #1 seen_clr = 1'b1;
        @(posedge i_clk);
        #1 seen_clr = 1'b0;
        for (int b = 0; b < 256; b++)
            drive(1'b1, SBOX_SM4, 8'(b), b < 16, sm4_head_ref(4'(b)), 1'b1);
        drain();
        report("sm4", fails0, chks0);
    endtask

    // Random ops and gaps with SM4 limited to the known row
    task automatic mixed_stream();
        int         fails0;
        int         chks0;
        logic       vld;
        sbox_op_e   op;
        logic [7:0] b;
        fails0 = fail_cnt;
        chks0  = chk_cnt;
        for (int n = 0; n < 300; n++) begin
            vld = ($urandom_range(3, 0) != 0);
            op  = sbox_op_e'($urandom_range(2, 0));
            b   = 8'($urandom);
            case (op)
                SBOX_AES_FWD: drive(vld, op, b, 1'b1, aes_fwd_ref(b), 1'b0);
                SBOX_AES_INV: drive(vld, op, aes_fwd_ref(b), 1'b1, b, 1'b0);
                default:      drive(vld, op, {4'h0, b[3:0]}, 1'b1, sm4_head_ref(b[3:0]), 1'b0);
            endcase
        end
        drain();
        report("mixed", fails0, chks0);
    endtask

    initial begin
        i_clk    = 1'b0;
        i_rst_n  = 1'b1;
        i_valid  = 1'b0;
        i_op     = SBOX_AES_FWD;
        i_byte   = '0;
        chk_d    = 1'b0;
        uniq_d   = 1'b0;
        exp_d    = '0;
        seen_clr = 1'b0;
        void'($urandom(32'haeb6));
        #1 i_rst_n = 1'b0;  // Falling edge resets the DUT before the first clock
        repeat (16) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        idle_after_reset();
        aes_forward_sweep();
        aes_inverse_roundtrip();
        sm4_sweep();
        mixed_stream();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, fail_cnt);
        if (fail_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
+incdir+tests
design/sbox_pkg.sv
design/sbox_inner_layer.sv
design/sbox_nonlinear_core.sv
design/sbox_outer_layer.sv
design/sbox_unit.sv
tests/sbox_unit_tb.sv

//--- Bender.yml
package:
  name: sbox_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/sbox_pkg.sv
      - design/sbox_inner_layer.sv
      - design/sbox_nonlinear_core.sv
      - design/sbox_outer_layer.sv
      - design/sbox_unit.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/sbox_unit_tb.sv
